/* list.f */
+incdir+logic
logic/bridge_pkg.sv
logic/cmd_decode.sv
logic/cmd_queue.sv
logic/bus_execute.sv
logic/result_send.sv
logic/bridge_master.sv
tb/bridge_checker.sv
tb/tb_bridge_master.sv

/* logic/bridge_defs.svh */
/*
 * Bridge master widths, FIFO depth and UART bit timing
 */
`ifndef BRIDGE_DEFS_SVH
`define BRIDGE_DEFS_SVH

// ----------------------------------------
// Datapath widths
// ----------------------------------------
`define BRIDGE_DATA_W       8   // One data byte on bus and UART
`define BRIDGE_BB_ADDR_W    12  // Address as sent by the remote side
`define BRIDGE_BUS_ADDR_W   16  // Local bus address after mapping
`define BRIDGE_FRAME_W      21  // {mode, data, bb_addr}

// ----------------------------------------
// Queue and UART
// ----------------------------------------
`define BRIDGE_QUEUE_DEPTH  8   // Pending commands, power of two

// Clocks per UART bit, short so that simulation stays fast
`define BRIDGE_CLKS_PER_BIT 16

`endif

/* logic/bridge_master.sv */
/*
 * Bridge master top: UART commands in, local bus transactions out,
 * read results back over UART
 */
`timescale 1ns/1ps
`default_nettype none

`include "bridge_defs.svh"

module bridge_master (
    input  wire logic                       clk,
    input  wire logic                       rstn,
    // Remote UART
    input  wire logic                       u_rx,
    output logic                            u_tx,
    // Local bus
    output logic                            bus_breq,
    input  wire logic                       bus_grant,
    output bridge_pkg::bus_req_t            bus_out,
    output logic                            bus_valid,
    input  wire logic                       bus_ack,
    input  wire logic [`BRIDGE_DATA_W-1:0]  bus_rdata,
    input  wire logic                       bus_rvalid
);

    bridge_pkg::bridge_cmd_t   cmd;       // Decoder to queue
    logic                      cmd_valid;
    bridge_pkg::bridge_cmd_t   head;      // Queue to execute
    logic                      empty;
    logic                      pop;
    logic [`BRIDGE_DATA_W-1:0] rd_data;   // Execute to result
    logic                      rd_valid;
    logic                      tx_busy;

    // ----------------------------------------
    // Decode, queue, execute, result
    // ----------------------------------------
    cmd_decode cmd_decode_i (
        .clk(clk), .rstn(rstn), .u_rx(u_rx), .cmd(cmd), .cmd_valid(cmd_valid)
    );

    cmd_queue cmd_queue_i (
        .clk(clk), .rstn(rstn), .push(cmd_valid), .din(cmd),
        .pop(pop), .head(head), .empty(empty)
    );

    bus_execute bus_execute_i (
        .clk(clk), .rstn(rstn), .head(head), .empty(empty), .pop(pop),
        .tx_busy(tx_busy), .rd_data(rd_data), .rd_valid(rd_valid),
        .bus_breq(bus_breq), .bus_grant(bus_grant), .bus_out(bus_out),
        .bus_valid(bus_valid), .bus_ack(bus_ack),
        .bus_rdata(bus_rdata), .bus_rvalid(bus_rvalid)
    );

    result_send result_send_i (
        .clk(clk), .rstn(rstn), .rd_data(rd_data), .rd_valid(rd_valid),
        .u_tx(u_tx), .tx_busy(tx_busy)
    );

endmodule

`default_nettype wire

/* logic/bridge_pkg.sv */
/*
 * Bridge master types: commands, bus transactions, FSM states
 */
`default_nettype none

`include "bridge_defs.svh"

package bridge_pkg;

    // Bus operation, same encoding as the frame mode bit
    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } cmd_op_t;

    // ----------------------------------------
    // Decoded command, bit layout equals the UART frame
    // ----------------------------------------
    typedef struct packed {
        cmd_op_t                      op;      // Bit 20
        logic [`BRIDGE_DATA_W-1:0]    data;    // Bits 19:12
        logic [`BRIDGE_BB_ADDR_W-1:0] bb_addr; // Bits 11:0
    } bridge_cmd_t;

    // One transaction as driven on the local bus
    typedef struct packed {
        cmd_op_t                       op;
        logic [`BRIDGE_BUS_ADDR_W-1:0] addr;  // Mapped address
        logic [`BRIDGE_DATA_W-1:0]     wdata; // Don't care on reads
    } bus_req_t;

    // Execute FSM
    typedef enum logic [1:0] {
        EX_IDLE,  // Waiting for a command
        EX_REQ,   // Bus requested, no grant yet
        EX_ISSUE, // bus_valid cycle
        EX_WAIT   // Waiting for ack or read data
    } exec_state_t;

    // UART RX and TX share the same phases
    typedef enum logic [1:0] {
        U_IDLE,
        U_START,
        U_DATA,
        U_STOP
    } uart_state_t;

endpackage

`default_nettype wire

/* logic/bus_execute.sv */
/*
 * Bus master: takes queued commands, maps the address and runs
 * one request/grant/valid/ack transaction per command
 */
`timescale 1ns/1ps
`default_nettype none

`include "bridge_defs.svh"

module bus_execute (
    input  wire logic                       clk,
    input  wire logic                       rstn,
    // Queue side
    input  wire bridge_pkg::bridge_cmd_t    head,
    input  wire logic                       empty,
    output logic                            pop,
    // Result side
    input  wire logic                       tx_busy,
    output logic [`BRIDGE_DATA_W-1:0]       rd_data,
    output logic                            rd_valid,
    // Local bus
    output logic                            bus_breq,
    input  wire logic                       bus_grant,
    output bridge_pkg::bus_req_t            bus_out,
    output logic                            bus_valid,
    input  wire logic                       bus_ack,
    input  wire logic [`BRIDGE_DATA_W-1:0]  bus_rdata,
    input  wire logic                       bus_rvalid
);

    bridge_pkg::exec_state_t state_q;
    bridge_pkg::bus_req_t    req_q;   // Latched transaction, held to the end
    logic                    go;      // Leave idle with the head command
    logic                    active;  // Valid cycle or waiting
    logic                    done;    // Transaction ends this cycle
    logic                    rd_hit;  // Read data arrives

    // ----------------------------------------
    // Address mapping
    // ----------------------------------------
    // bb[11:10] -> bus[15:12], bb[9:0] -> bus[11:0]
    function automatic logic [`BRIDGE_BUS_ADDR_W-1:0] map_addr(
        input logic [`BRIDGE_BB_ADDR_W-1:0] bb
    );
        map_addr = {2'b00, bb[11:10], 2'b00, bb[9:0]};
    endfunction

    // A read waits until the TX path is free, so its byte is never lost
    assign go = (state_q == bridge_pkg::EX_IDLE) && !empty &&
                (head.op == bridge_pkg::OP_WRITE || (!tx_busy && !rd_valid));

    assign pop       = go;                                 // Same cycle as leaving idle
    assign bus_breq  = (state_q != bridge_pkg::EX_IDLE);  // Held until the end
    assign bus_valid = (state_q == bridge_pkg::EX_ISSUE);  // Exactly one cycle
    assign bus_out   = req_q;

    assign active = (state_q == bridge_pkg::EX_ISSUE) || (state_q == bridge_pkg::EX_WAIT);
    assign done   = active &&
                    ((req_q.op == bridge_pkg::OP_WRITE) ? bus_ack : bus_rvalid);
    assign rd_hit = active && (req_q.op == bridge_pkg::OP_READ) && bus_rvalid;

    // ----------------------------------------
    // Control FSM
    // ----------------------------------------
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state_q  <= bridge_pkg::EX_IDLE;
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= rd_hit;                   // One cycle after bus_rvalid
            case (state_q)
                bridge_pkg::EX_IDLE:
                    if (go) state_q <= bridge_pkg::EX_REQ;
                bridge_pkg::EX_REQ:
                    if (bus_grant) state_q <= bridge_pkg::EX_ISSUE;
                bridge_pkg::EX_ISSUE:              // Fast slave may end it right away
                    state_q <= done ? bridge_pkg::EX_IDLE : bridge_pkg::EX_WAIT;
                bridge_pkg::EX_WAIT:
                    if (done) state_q <= bridge_pkg::EX_IDLE;
                default: state_q <= bridge_pkg::EX_IDLE;
            endcase
        end
    end

    // Payload registers
    always_ff @(posedge clk) begin
        if (go) begin
            req_q.op    <= head.op;
            req_q.addr  <= map_addr(head.bb_addr);
            req_q.wdata <= head.data;
        end
        if (rd_hit)
            rd_data <= bus_rdata;
    end

    // ----------------------------------------
    // Bus protocol checks
    // ----------------------------------------
    a_valid_granted : assert property (@(posedge clk) disable iff (!rstn)
        bus_valid |-> bus_breq && bus_grant);

    a_out_stable : assert property (@(posedge clk) disable iff (!rstn)
        (state_q == bridge_pkg::EX_WAIT) |-> $stable(bus_out));

endmodule

`default_nettype wire

/* logic/cmd_decode.sv */
/*
 * Command decoder: UART receiver for 21-bit frames, LSB first,
 * presents each good frame as a typed command for one cycle
 */
`timescale 1ns/1ps
`default_nettype none

`include "bridge_defs.svh"

module cmd_decode (
    input  wire logic                   clk,
    input  wire logic                   rstn,
    input  wire logic                   u_rx,
    output bridge_pkg::bridge_cmd_t     cmd,
    output logic                        cmd_valid
);

    localparam int CNT_W = $clog2(`BRIDGE_CLKS_PER_BIT);
    localparam int IDX_W = $clog2(`BRIDGE_FRAME_W);
    localparam int HALF  = `BRIDGE_CLKS_PER_BIT / 2;

    logic                       rx_meta;   // First sync stage
    logic                       rx_sync;   // Safe to use
    bridge_pkg::uart_state_t    state_q;
    logic [CNT_W-1:0]           cnt_q;     // Clocks within a bit
    logic [IDX_W-1:0]           idx_q;     // Frame bit index
    logic [`BRIDGE_FRAME_W-1:0] shift_q;   // Frame being assembled
    logic                       bit_end;   // Mid-bit sample point
    logic                       half_end;  // Middle of the start bit

    // ----------------------------------------
    // Two-flop synchronizer, idles high
    // ----------------------------------------
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= u_rx;
            rx_sync <= rx_meta;
        end
    end

    assign bit_end  = (cnt_q == CNT_W'(`BRIDGE_CLKS_PER_BIT - 1));
    assign half_end = (cnt_q == CNT_W'(HALF - 1));

    // ----------------------------------------
    // Receive FSM
    // ----------------------------------------
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state_q   <= bridge_pkg::U_IDLE;
            cnt_q     <= '0;
            idx_q     <= '0;
            cmd_valid <= 1'b0;
        end else begin
            cmd_valid <= 1'b0;                   // Strobe by default
            case (state_q)
                bridge_pkg::U_IDLE: begin
                    cnt_q <= '0;
                    idx_q <= '0;
                    if (!rx_sync)                // Falling edge, start bit begins
                        state_q <= bridge_pkg::U_START;
                end
                bridge_pkg::U_START: begin
                    if (half_end) begin
                        cnt_q <= '0;             // From here on, count whole bits
                        // Glitch check, line must still be low
                        state_q <= rx_sync ? bridge_pkg::U_IDLE : bridge_pkg::U_DATA;
                    end else begin
                        cnt_q <= cnt_q + 1'b1;
                    end
                end
                bridge_pkg::U_DATA: begin
                    if (bit_end) begin
                        cnt_q <= '0;
                        idx_q <= idx_q + 1'b1;
                        if (idx_q == IDX_W'(`BRIDGE_FRAME_W - 1))
                            state_q <= bridge_pkg::U_STOP;
                    end else begin
                        cnt_q <= cnt_q + 1'b1;
                    end
                end
                bridge_pkg::U_STOP: begin
                    if (bit_end) begin
                        state_q   <= bridge_pkg::U_IDLE;
                        cmd_valid <= rx_sync;    // Bad stop bit drops the frame
                    end else begin
                        cnt_q <= cnt_q + 1'b1;
                    end
                end
                default: state_q <= bridge_pkg::U_IDLE;
            endcase
        end
    end

    // Payload path, LSB arrives first so shift in from the top
    always_ff @(posedge clk) begin
        if (state_q == bridge_pkg::U_DATA && bit_end)
            shift_q <= {rx_sync, shift_q[`BRIDGE_FRAME_W-1:1]};
        if (state_q == bridge_pkg::U_STOP && bit_end && rx_sync)
            cmd <= bridge_pkg::bridge_cmd_t'(shift_q);
    end

    // Frames are far apart, a strobe never lasts two cycles
    a_valid_pulse : assert property (@(posedge clk) disable iff (!rstn)
        cmd_valid |=> !cmd_valid);

endmodule

`default_nettype wire

/* logic/cmd_queue.sv */
/*
 * Command FIFO between decoder and bus execute, circular buffer
 */
`timescale 1ns/1ps
`default_nettype none

`include "bridge_defs.svh"

module cmd_queue #(
    parameter int DEPTH = `BRIDGE_QUEUE_DEPTH  // Power of two
) (
    input  wire logic                     clk,
    input  wire logic                     rstn,
    input  wire logic                     push,
    input  wire bridge_pkg::bridge_cmd_t  din,
    input  wire logic                     pop,
    output bridge_pkg::bridge_cmd_t       head,
    output logic                          empty
);

    localparam int AW = $clog2(DEPTH);

    bridge_pkg::bridge_cmd_t mem [DEPTH];  // Storage, no reset needed
    logic [AW-1:0]           wr_ptr;
    logic [AW-1:0]           rd_ptr;
    logic [AW:0]             count;        // One extra bit for full
    logic                    full;
    logic                    do_push;
    logic                    do_pop;

    assign full    = (count == (AW+1)'(DEPTH));
    assign empty   = (count == '0);
    assign do_push = push && !full;        // Overflow is dropped
    assign do_pop  = pop && !empty;
    assign head    = mem[rd_ptr];          // First-word fall-through

    always_ff @(posedge clk) begin
        if (do_push)
            mem[wr_ptr] <= din;
    end

    // Pointers wrap naturally for power-of-two depth
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= wr_ptr + 1'b1;
            if (do_pop)  rd_ptr <= rd_ptr + 1'b1;
            count <= count + (AW+1)'(do_push) - (AW+1)'(do_pop);
        end
    end

    // Execute must only pop what exists
    a_no_underflow : assert property (@(posedge clk) disable iff (!rstn)
        pop |-> !empty);

endmodule

`default_nettype wire

/* logic/result_send.sv */
/*
 * Result sender: UART transmitter for read data bytes,
 * start bit, 8 data bits LSB first, stop bit
 */
`timescale 1ns/1ps
`default_nettype none

`include "bridge_defs.svh"

module result_send (
    input  wire logic                       clk,
    input  wire logic                       rstn,
    input  wire logic [`BRIDGE_DATA_W-1:0]  rd_data,
    input  wire logic                       rd_valid,
    output logic                            u_tx,
    output logic                            tx_busy
);

    localparam int CNT_W = $clog2(`BRIDGE_CLKS_PER_BIT);
    localparam int IDX_W = $clog2(`BRIDGE_DATA_W);

    bridge_pkg::uart_state_t   state_q;
    logic [CNT_W-1:0]          cnt_q;    // Clocks within a bit
    logic [IDX_W-1:0]          idx_q;    // Data bit being sent
    logic [`BRIDGE_DATA_W-1:0] shift_q;  // Bit 0 is on the line
    logic                      bit_end;

    assign bit_end = (cnt_q == CNT_W'(`BRIDGE_CLKS_PER_BIT - 1));
    assign tx_busy = (state_q != bridge_pkg::U_IDLE);  // Start through stop

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state_q <= bridge_pkg::U_IDLE;
            cnt_q   <= '0;
            idx_q   <= '0;
            u_tx    <= 1'b1;                     // Line idles high
        end else begin
            cnt_q <= bit_end ? '0 : cnt_q + 1'b1;
            case (state_q)
                bridge_pkg::U_IDLE: begin
                    cnt_q <= '0;
                    idx_q <= '0;
                    u_tx  <= 1'b1;
                    if (rd_valid) begin
                        state_q <= bridge_pkg::U_START;
                        u_tx    <= 1'b0;         // Start bit next cycle
                    end
                end
                bridge_pkg::U_START:
                    if (bit_end) begin
                        state_q <= bridge_pkg::U_DATA;
                        u_tx    <= shift_q[0];
                    end
                bridge_pkg::U_DATA:
                    if (bit_end) begin
                        if (idx_q == IDX_W'(`BRIDGE_DATA_W - 1)) begin
                            state_q <= bridge_pkg::U_STOP;
                            u_tx    <= 1'b1;     // Stop bit
                        end else begin
                            idx_q <= idx_q + 1'b1;
                            u_tx  <= shift_q[1]; // Next bit before the shift lands
                        end
                    end
                bridge_pkg::U_STOP:
                    if (bit_end) state_q <= bridge_pkg::U_IDLE;
                default: state_q <= bridge_pkg::U_IDLE;
            endcase
        end
    end

    // Byte shifter
    always_ff @(posedge clk) begin
        if (state_q == bridge_pkg::U_IDLE && rd_valid)
            shift_q <= rd_data;
        else if (state_q == bridge_pkg::U_DATA && bit_end)
            shift_q <= shift_q >> 1;
    end

    // Execute holds reads back while busy, so no byte is overwritten
    a_no_overrun : assert property (@(posedge clk) disable iff (!rstn)
        rd_valid |-> !tx_busy);

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# Build the bridge master testbench with Verilator, run it, check the log
rm -f sim.log
verilator --binary --timing --assert -f list.f --top-module tb_bridge_master -o sim_bridge \
    && ./obj_dir/sim_bridge > sim.log 2>&1 || echo "build or run error" >> sim.log
cat sim.log
grep -q "Result: PASSED" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }

/* tb/bridge_checker.sv */
/*
 * Bridge checker that follows each sent command through a reference
 * memory and compares bus transactions and UART result bytes
 */
`timescale 1ns/1ps
`default_nettype none

`include "bridge_defs.svh"

module bridge_checker (
    input  wire logic                    clk,
    input  wire logic                    rstn,
    input  wire logic                    sent_strobe,  // One cycle per frame sent
    input  wire bridge_pkg::bridge_cmd_t sent_cmd,
    input  wire logic                    bus_breq,
    input  wire logic                    bus_valid,
    input  wire bridge_pkg::bus_req_t    bus_out,
    input  wire logic                    u_tx,
    output int                           checks,
    output int                           errors,
    output int                           pending       // Commands or bytes not yet seen
);

    localparam int BIT = `BRIDGE_CLKS_PER_BIT;

    logic [7:0]           ref_mem [logic [15:0]];  // Memory as the remote side sees it
    bridge_pkg::bus_req_t exp_bus [$];             // Bus transactions in send order
    logic [7:0]           exp_rd  [$];             // Bytes due on u_tx
    int                   bus_checks = 0;
    int                   bus_errors = 0;
    int                   tx_checks  = 0;
    int                   tx_errors  = 0;
    logic                 rstn_q;

    // Page bits 11:10 move up to 15:12 and the offset stays at the bottom
    function automatic logic [15:0] bus_addr_of(input logic [11:0] bb);
        return 16'((int'(bb) / 1024) * 4096 + int'(bb) % 1024);
    endfunction

    task automatic show_mismatch(input string name, input logic [15:0] got,
                                 input logic [15:0] exp);
        $display("[ERROR] t=%0t %s got %h expected %h", $time, name, got, exp);
    endtask

    // ----------------------------------------
    // Reset state, model update, bus compare
    // ----------------------------------------
    always @(posedge clk) begin : bus_side
        bridge_pkg::bus_req_t exp;
        logic [15:0]          a;
        rstn_q <= rstn;
        if (rstn && !rstn_q) begin               // First edge out of reset
            bus_checks++;
            if (bus_breq !== 1'b0) begin
                bus_errors++;
                show_mismatch("bus_breq", 16'(bus_breq), 16'h0);
            end
            if (bus_valid !== 1'b0) begin
                bus_errors++;
                show_mismatch("bus_valid", 16'(bus_valid), 16'h0);
            end
            if (u_tx !== 1'b1) begin
                bus_errors++;
                show_mismatch("u_tx", 16'(u_tx), 16'h1);
            end
        end
        if (rstn && sent_strobe) begin
            a         = bus_addr_of(sent_cmd.bb_addr);
            exp.op    = sent_cmd.op;
            exp.addr  = a;
            exp.wdata = sent_cmd.data;
            exp_bus.push_back(exp);
            if (sent_cmd.op == bridge_pkg::OP_WRITE)
                ref_mem[a] = sent_cmd.data;
            else
                exp_rd.push_back(ref_mem.exists(a) ? ref_mem[a] : 8'h00);  // Unwritten reads 0
        end
        if (rstn && bus_valid) begin
            bus_checks++;
            if (exp_bus.size() == 0) begin
                bus_errors++;
                $display("Bus transaction at %0t with no command outstanding", $time);
            end else begin
                exp = exp_bus.pop_front();
                if (bus_out.op !== exp.op) begin
                    bus_errors++;
                    show_mismatch("bus_out.op", 16'(bus_out.op), 16'(exp.op));
                end
                if (bus_out.addr !== exp.addr) begin
                    bus_errors++;
                    show_mismatch("bus_out.addr", bus_out.addr, exp.addr);
                end
                if (exp.op == bridge_pkg::OP_WRITE && bus_out.wdata !== exp.wdata) begin
                    bus_errors++;
                    show_mismatch("bus_out.wdata", 16'(bus_out.wdata), 16'(exp.wdata));
                end
            end
        end
    end

    // ----------------------------------------
    // UART result decode at mid-bit
    // ----------------------------------------
    initial begin : tx_side
        logic [7:0] got;
        logic [7:0] exp;
        forever begin
            @(posedge clk);
            if (rstn && u_tx === 1'b0) begin     // Start bit seen
                repeat (BIT/2 - 1) @(posedge clk);
                for (int i = 0; i < 8; i++) begin
                    repeat (BIT) @(posedge clk);
                    got[i] = u_tx;               // LSB first
                end
                repeat (BIT) @(posedge clk);
                tx_checks++;
                if (u_tx !== 1'b1) begin
                    tx_errors++;
                    $display("Missing stop bit on u_tx at %0t", $time);
                end
                if (exp_rd.size() == 0) begin
                    tx_errors++;
                    $display("Byte %h on u_tx at %0t with no read outstanding", got, $time);
                end else begin
                    exp = exp_rd.pop_front();
                    if (got !== exp) begin
                        tx_errors++;
                        show_mismatch("u_tx byte", 16'(got), 16'(exp));
                    end
                end
            end
        end
    end

    // Totals for the testbench top
    always @(negedge clk) begin
        checks  = bus_checks + tx_checks;
        errors  = bus_errors + tx_errors;
        pending = exp_bus.size() + exp_rd.size();
    end

endmodule

`default_nettype wire

/* tb/tb_bridge_master.sv */
/*
 * Bridge master testbench with LCG-driven UART command frames,
 * a bus slave memory model and the verdict from the checker counts
 */
`timescale 1ns/1ps
`default_nettype none

`include "bridge_defs.svh"

module tb_bridge_master;

    localparam int BIT         = `BRIDGE_CLKS_PER_BIT;
    localparam int DRAIN_LIMIT = 40000;  // Cycles per test
    localparam int GRANT_LIMIT = 50;     // Cycles from grant to bus_valid

    logic clk, rstn, u_rx, u_tx;
    logic bus_breq, bus_grant, bus_valid, bus_ack, bus_rvalid;
    logic [7:0]              bus_rdata;
    bridge_pkg::bus_req_t    bus_out;
    logic                    sent_strobe;
    bridge_pkg::bridge_cmd_t sent_cmd;
    int          checks, errors, pending;
    logic [31:0] stim_seed, bus_seed;
    logic [7:0]  slave_mem [logic [15:0]];  // Slave storage keyed by bus address
    logic [11:0] addr_set [8];              // Small set so reads hit writes
    int          tests, errors_before, drain_timeouts;
    int          slave_timeouts = 0;
    bit          abort, slow_grant;

    bridge_master bridge_master_i (
        .clk(clk), .rstn(rstn), .u_rx(u_rx), .u_tx(u_tx),
        .bus_breq(bus_breq), .bus_grant(bus_grant), .bus_out(bus_out),
        .bus_valid(bus_valid), .bus_ack(bus_ack),
        .bus_rdata(bus_rdata), .bus_rvalid(bus_rvalid)
    );

    bridge_checker checker_i (
        .clk(clk), .rstn(rstn), .sent_strobe(sent_strobe), .sent_cmd(sent_cmd),
        .bus_breq(bus_breq), .bus_valid(bus_valid), .bus_out(bus_out), .u_tx(u_tx),
        .checks(checks), .errors(errors), .pending(pending)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ----------------------------------------
    // UART command driver
    // ----------------------------------------
    task automatic send_frame(input bridge_pkg::bridge_cmd_t c);
        logic [`BRIDGE_FRAME_W+1:0] bits;
        bits = {1'b1, c, 1'b0};                 // Stop, payload, start
        @(negedge clk);
        sent_cmd    = c;
        sent_strobe = 1'b1;                     // Tell the checker
        for (int i = 0; i < `BRIDGE_FRAME_W + 2; i++) begin
            u_rx = bits[i];
            repeat (BIT) begin
                @(negedge clk);
                sent_strobe = 1'b0;
            end
        end
    endtask

    task automatic send_random(input int count, input int write_pct);
        bridge_pkg::bridge_cmd_t c;
        for (int n = 0; n < count; n++) begin
            stim_seed = lcg_next(stim_seed);
            c.op = (int'(stim_seed[23:16]) % 100 < write_pct) ?
                   bridge_pkg::OP_WRITE : bridge_pkg::OP_READ;
            stim_seed = lcg_next(stim_seed);
            c.data    = stim_seed[23:16];
            stim_seed = lcg_next(stim_seed);
            c.bb_addr = addr_set[stim_seed[18:16]];
            send_frame(c);
        end
    endtask

    // Write every address of the set and read each one back
    task automatic write_then_read();
        bridge_pkg::bridge_cmd_t c;
        for (int i = 0; i < 8; i++) begin
            stim_seed = lcg_next(stim_seed);
            c = '{op: bridge_pkg::OP_WRITE, data: stim_seed[23:16], bb_addr: addr_set[i]};
            send_frame(c);
        end
        for (int i = 7; i >= 0; i--) begin
            c = '{op: bridge_pkg::OP_READ, data: 8'h00, bb_addr: addr_set[i]};
            send_frame(c);
        end
    endtask

    task automatic wait_drain(input string what);
        int n;
        n = 0;
        while ((pending != 0 || bus_breq) && n < DRAIN_LIMIT) begin
            @(posedge clk);                     // Totals move on negedge
            n++;
        end
        if (pending != 0 || bus_breq || slave_timeouts != 0) begin
            $display("Timeout: %s did not finish, %0d items outstanding", what, pending);
            drain_timeouts++;
            abort = 1'b1;
        end
    endtask

    task automatic finish_test(input string name);
        @(posedge clk);                         // Checker totals settle on negedge
        tests++;
        $display("Test %0d %s: %s (%0d errors)", tests, name,
                 (errors == errors_before && !abort) ? "ok" : "failed",
                 errors - errors_before);
        errors_before = errors;
    endtask

    // ----------------------------------------
    // Bus slave with memory
    // ----------------------------------------
    initial begin : slave
        int                   delay;
        int                   n;
        bridge_pkg::bus_req_t req;
        bus_grant  = 1'b0;
        bus_ack    = 1'b0;
        bus_rvalid = 1'b0;
        bus_rdata  = 8'h00;
        forever begin
            @(negedge clk);
            if (rstn && bus_breq && !bus_grant) begin
                bus_seed = lcg_next(bus_seed);
                delay    = slow_grant ? 5 : int'(bus_seed[23:16]) % 6;  // 0 to 5 cycles
                repeat (delay) @(negedge clk);
                bus_grant = 1'b1;
                n = 0;
                while (!bus_valid && n < GRANT_LIMIT) begin
                    @(negedge clk);
                    n++;
                end
                if (!bus_valid) begin
                    $display("Timeout: no bus_valid after grant at %0t", $time);
                    slave_timeouts++;
                end else begin
                    req      = bus_out;
                    bus_seed = lcg_next(bus_seed);
                    repeat (int'(bus_seed[23:16]) % 4) @(negedge clk);
                    if (req.op == bridge_pkg::OP_WRITE) begin
                        slave_mem[req.addr] = req.wdata;
                        bus_ack = 1'b1;
                    end else begin
                        bus_rdata  = slave_mem.exists(req.addr) ? slave_mem[req.addr] : 8'h00;
                        bus_rvalid = 1'b1;
                    end
                    @(negedge clk);
                    bus_ack    = 1'b0;
                    bus_rvalid = 1'b0;
                end
                bus_grant = 1'b0;               // bus_breq is low by now
            end
        end
    end

    // ----------------------------------------
    // Test sequence
    // ----------------------------------------
    initial begin
        rstn           = 1'b0;
        u_rx           = 1'b1;                  // Line idles high
        sent_strobe    = 1'b0;
        sent_cmd       = '0;
        stim_seed      = 32'h5c84;
        bus_seed       = 32'h5c84;
        tests          = 0;
        errors_before  = 0;
        drain_timeouts = 0;
        abort          = 1'b0;
        slow_grant     = 1'b0;
        addr_set = '{12'h000, 12'h3ff, 12'h400, 12'h7a5, 12'h801, 12'hc3c, 12'hfff, 12'h155};
        repeat (16) @(negedge clk);
        rstn = 1'b1;
        repeat (4) @(negedge clk);
        finish_test("reset state");
        if (!abort) begin
            send_random(24, 50);
            wait_drain("random mix");
            finish_test("write mapping and read result");
        end
        if (!abort) begin
            slow_grant = 1'b1;                  // Grants at the long end
            send_random(12, 40);
            wait_drain("burst");
            slow_grant = 1'b0;
            finish_test("order under bursts");
        end
        if (!abort) begin
            write_then_read();
            wait_drain("read after write");
            finish_test("read after write");
        end
        $display("Tests %0d, checks %0d, errors %0d, timeouts %0d",
                 tests, checks, errors, drain_timeouts);
        if (tests == 4 && errors == 0 && drain_timeouts == 0 && checks > 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule

`default_nettype wire
